// ==== rtl/buf_pkg.sv ====
package buf_pkg;

    // Data word width of the buffer and of the register port.
    localparam int WORD_W = 32;

    // Number of words in the tile RAM.
    localparam int DEPTH = 64;

    localparam int ADDR_W = $clog2(DEPTH);

    // Credits on each stream. Also the depth of the writer queue.
    localparam int CREDITS = 4;

    typedef logic [WORD_W-1:0] word_t;

    // RAM address. Increments wrap modulo DEPTH.
    typedef logic [ADDR_W-1:0] addr_t;

    // Word count. One bit wider than an address so a full RAM fits.
    typedef logic [ADDR_W:0] len_t;

    // Credit counter, holds 0 to CREDITS.
    typedef logic [$clog2(CREDITS):0] credit_t;

endpackage

// ==== rtl/cfg_pkg.sv ====
package cfg_pkg;

    // Register index on the configuration port.
    typedef logic [2:0] reg_addr_t;

    // Register map.
    // CTRL bit 0 written with 1 starts a read.
    // STATUS is read-only: bit 0 is busy, bits 14:8 the words-written count.
    typedef enum reg_addr_t {
        REG_WR_BASE = 3'd0,
        REG_RD_BASE = 3'd1,
        REG_RD_LEN  = 3'd2,
        REG_CTRL    = 3'd3,
        REG_STATUS  = 3'd4
    } reg_idx_e;

    // States of the read engine.
    typedef enum logic [1:0] {
        RD_IDLE  = 2'd0,
        RD_RUN   = 2'd1,
        RD_DRAIN = 2'd2
    } rd_state_e;

endpackage

// ==== rtl/sram_wrap.sv ====
`timescale 1ns/100ps

module sram_wrap (
    input  logic           clk,
    input  logic           rst,
    input  logic           en_rd,
    input  logic           en_wr,
    input  buf_pkg::addr_t addr,
    input  buf_pkg::word_t wdata,
    output buf_pkg::word_t rdata
);
    import buf_pkg::*;

    word_t mem [DEPTH];
    word_t dout;    // Array output, changes on every access like a macro would.
    word_t hold;
    logic  rd_en_d;

    // The array output follows writes too, so it cannot be relied on
    // after the cycle that follows a read.
    always_ff @(posedge clk) begin
        if (en_wr) begin
            mem[addr] <= wdata;
            dout      <= wdata;
        end else if (en_rd) begin
            dout <= mem[addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_d <= 1'b0;
            hold    <= '0;
        end else begin
            rd_en_d <= en_rd;
            if (rd_en_d) begin
                hold <= dout; // Keep the last read word.
            end
        end
    end

    // Fresh data in the cycle after a read, the held word otherwise.
    assign rdata = rd_en_d ? dout : hold;

endmodule

// ==== rtl/buf_cfg_regs.sv ====
`timescale 1ns/100ps

module buf_cfg_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we,
    input  cfg_pkg::reg_addr_t   cfg_addr,
    input  buf_pkg::word_t       cfg_wdata,
    output buf_pkg::word_t       cfg_rdata,
    input  logic                 rd_busy,
    input  buf_pkg::len_t        wr_count,
    output buf_pkg::addr_t       wr_base,
    output buf_pkg::addr_t       rd_base,
    output buf_pkg::len_t        rd_len,
    output logic                 wr_load,
    output logic                 rd_start
);
    import buf_pkg::*;
    import cfg_pkg::*;

    logic wr_base_we;

    assign wr_base_we = cfg_we && (cfg_addr == REG_WR_BASE);

    // A start while a read is running is dropped here.
    assign rd_start = cfg_we && (cfg_addr == REG_CTRL) && cfg_wdata[0] && !rd_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_base <= '0;
            rd_base <= '0;
            rd_len  <= '0;
            wr_load <= 1'b0;
        end else begin
            // The load follows the base write by one cycle, so the writer
            // picks up the new value.
            wr_load <= wr_base_we;
            if (wr_base_we) begin
                wr_base <= addr_t'(cfg_wdata);
            end
            if (cfg_we && (cfg_addr == REG_RD_BASE)) begin
                rd_base <= addr_t'(cfg_wdata);
            end
            if (cfg_we && (cfg_addr == REG_RD_LEN)) begin
                rd_len <= len_t'(cfg_wdata);
            end
        end
    end

    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            REG_WR_BASE: begin
                cfg_rdata = word_t'(wr_base);
            end
            REG_RD_BASE: begin
                cfg_rdata = word_t'(rd_base);
            end
            REG_RD_LEN: begin
                cfg_rdata = word_t'(rd_len);
            end
            REG_STATUS: begin
                cfg_rdata[0]                   = rd_busy;
                cfg_rdata[8 +: $bits(len_t)]   = wr_count;
            end
            default: begin
                cfg_rdata = '0; // CTRL and unused indices read as zero.
            end
        endcase
    end

endmodule

// ==== rtl/buf_writer.sv ====
`timescale 1ns/100ps

module buf_writer (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  buf_pkg::word_t in_data,
    output logic           in_credit,
    input  buf_pkg::addr_t wr_base,
    input  logic           wr_load,
    input  logic           ram_rd_en,
    output logic           ram_wr_en,
    output buf_pkg::addr_t ram_wr_addr,
    output buf_pkg::word_t ram_wr_data,
    output buf_pkg::len_t  wr_count
);
    import buf_pkg::*;

    word_t                        q_mem [CREDITS];
    logic [$clog2(CREDITS)-1:0]   q_wr_ptr;
    logic [$clog2(CREDITS)-1:0]   q_rd_ptr;
    credit_t                      q_cnt;
    addr_t                        wr_addr;

    // The upstream sender never has more than CREDITS words outstanding,
    // and a word stays outstanding until it is written, so the queue
    // cannot overflow.

    // Reads own the port. A queued word goes out in the first free cycle.
    assign ram_wr_en   = (q_cnt != '0) && !ram_rd_en;
    assign ram_wr_addr = wr_addr;
    assign ram_wr_data = q_mem[q_rd_ptr];
    assign in_credit   = ram_wr_en;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_mem[q_wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
        end else begin
            if (in_valid) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (ram_wr_en) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + credit_t'(in_valid) - credit_t'(ram_wr_en);
        end
    end

    // A load wins over a write in the same cycle. That write still used
    // the old address, the next one uses the new base.
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr  <= '0;
            wr_count <= '0;
        end else if (wr_load) begin
            wr_addr  <= wr_base;
            wr_count <= '0;
        end else if (ram_wr_en) begin
            wr_addr  <= wr_addr + 1'b1; // Wraps modulo DEPTH.
            wr_count <= wr_count + 1'b1;
        end
    end

endmodule

// ==== rtl/buf_reader.sv ====
`timescale 1ns/100ps

module buf_reader (
    input  logic           clk,
    input  logic           rst,
    input  logic           rd_start,
    input  buf_pkg::addr_t rd_base,
    input  buf_pkg::len_t  rd_len,
    input  logic           out_credit,
    output logic           rd_busy,
    output logic           ram_rd_en,
    output buf_pkg::addr_t ram_rd_addr,
    input  buf_pkg::word_t ram_rd_data,
    output logic           out_valid,
    output buf_pkg::word_t out_data
);
    import buf_pkg::*;
    import cfg_pkg::*;

    rd_state_e state;
    rd_state_e state_nxt;
    addr_t     rd_addr;
    len_t      remain;     // Words still to be read.
    credit_t   credits;
    logic      last_read;

    assign rd_busy     = (state != RD_IDLE);
    assign ram_rd_en   = (state == RD_RUN) && (credits != '0) && (remain != '0);
    assign ram_rd_addr = rd_addr;

    // RAM data arrives one cycle after the read, in step with out_valid.
    assign out_data    = ram_rd_data;

    assign last_read   = ram_rd_en && (remain == len_t'(1));

    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE: begin
                if (rd_start) begin
                    state_nxt = RD_RUN;
                end
            end
            RD_RUN: begin
                // A zero length passes straight through to DRAIN.
                if (last_read || (remain == '0)) begin
                    state_nxt = RD_DRAIN;
                end
            end
            RD_DRAIN: begin
                state_nxt = RD_IDLE; // The last word is on the output now.
            end
            default: begin
                state_nxt = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr <= '0;
            remain  <= '0;
        end else if (rd_start) begin
            rd_addr <= rd_base; // A start only reaches us while idle.
            remain  <= rd_len;
        end else if (ram_rd_en) begin
            rd_addr <= rd_addr + 1'b1;
            remain  <= remain - 1'b1;
        end
    end

    // A returned credit and a spent one in the same cycle cancel out.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(CREDITS);
        end else begin
            credits <= credits - credit_t'(ram_rd_en) + credit_t'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= ram_rd_en;
        end
    end

endmodule

// ==== rtl/tile_buf_top.sv ====
`timescale 1ns/100ps

module tile_buf_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  cfg_pkg::reg_addr_t cfg_addr,
    input  buf_pkg::word_t     cfg_wdata,
    output buf_pkg::word_t     cfg_rdata,
    input  logic               in_valid,
    input  buf_pkg::word_t     in_data,
    output logic               in_credit,
    output logic               out_valid,
    output buf_pkg::word_t     out_data,
    input  logic               out_credit
);
    import buf_pkg::*;

    addr_t wr_base;
    addr_t rd_base;
    len_t  rd_len;
    len_t  wr_count;
    logic  wr_load;
    logic  rd_start;
    logic  rd_busy;

    logic  ram_rd_en;
    logic  ram_wr_en;
    addr_t ram_rd_addr;
    addr_t ram_wr_addr;
    addr_t ram_addr;
    word_t ram_wr_data;
    word_t ram_rd_data;

    // The writer stays off the port whenever a read is issued.
    assign ram_addr = ram_rd_en ? ram_rd_addr : ram_wr_addr;

    buf_cfg_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .rd_busy   (rd_busy),
        .wr_count  (wr_count),
        .wr_base   (wr_base),
        .rd_base   (rd_base),
        .rd_len    (rd_len),
        .wr_load   (wr_load),
        .rd_start  (rd_start)
    );

    buf_writer u_writer (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_credit   (in_credit),
        .wr_base     (wr_base),
        .wr_load     (wr_load),
        .ram_rd_en   (ram_rd_en),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_addr (ram_wr_addr),
        .ram_wr_data (ram_wr_data),
        .wr_count    (wr_count)
    );

    buf_reader u_reader (
        .clk         (clk),
        .rst         (rst),
        .rd_start    (rd_start),
        .rd_base     (rd_base),
        .rd_len      (rd_len),
        .out_credit  (out_credit),
        .rd_busy     (rd_busy),
        .ram_rd_en   (ram_rd_en),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    sram_wrap u_sram (
        .clk   (clk),
        .rst   (rst),
        .en_rd (ram_rd_en),
        .en_wr (ram_wr_en),
        .addr  (ram_addr),
        .wdata (ram_wr_data),
        .rdata (ram_rd_data)
    );

endmodule

// ==== dv/tile_buf_tb.sv ====
`timescale 1ns/100ps

module tile_buf_tb;
    import buf_pkg::*;
    import cfg_pkg::*;

    localparam int LIMIT = 2000;    // Cycles allowed for any single wait.
    localparam int N_TESTS = 6;

    typedef struct packed {
        addr_t wr_base;
        len_t  wr_num;
        addr_t rd_base;
        len_t  rd_len;
        logic  hold;    // Consumer withholds out_credit at first.
        logic  conc;    // Stream the words in while the read runs.
        logic  again;   // Repeat the start command during the read.
    } entry_t;

    logic      clk;
    logic      rst;
    logic      cfg_we;
    reg_addr_t cfg_addr;
    word_t     cfg_wdata;
    word_t     cfg_rdata;
    logic      in_valid;
    word_t     in_data;
    logic      in_credit;
    logic      out_valid;
    word_t     out_data;
    logic      out_credit;

    word_t  model [DEPTH];
    word_t  send_q [$];
    word_t  exp_q [$];
    entry_t tests [N_TESTS];
    entry_t e;
    addr_t  model_wr_addr;
    int     seed;
    int     in_sent;
    int     in_returned;
    int     out_seen;
    int     pend_credit;
    logic   withhold;
    int     errors;
    int     checks;
    word_t  rdata;

    tile_buf_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

    always #5 clk = ~clk;

    task automatic check_word(string name, word_t exp, word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_len(string name, len_t exp, len_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // One cycle at the falling edge. The upstream and consumer models sample
    // here and then drive the next values.
    task automatic tick();
        word_t w;
        @(negedge clk);
        if (in_credit) begin
            in_returned++;
        end
        if (in_returned > in_sent) begin
            errors++;
            $display("At %0t in_credit came back for a word that was never sent", $time);
        end
        if (out_valid) begin
            out_seen++;
            pend_credit++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("At %0t out_valid was raised with no word expected", $time);
            end else begin
                w = exp_q.pop_front();
                check_word("out_data", w, out_data);
            end
        end
        if (pend_credit > CREDITS) begin
            errors++;
            $display("At %0t more than %0d words came out without credit", $time, CREDITS);
        end
        out_credit = 1'b0;
        if (!withhold && pend_credit > 0) begin
            out_credit = 1'b1;
            pend_credit--;
        end
        in_valid = 1'b0;
        if (send_q.size() != 0 && (in_sent - in_returned) < CREDITS) begin
            in_valid = 1'b1;
            in_data  = send_q.pop_front();
            in_sent++;
        end
    endtask

    task automatic reg_write(reg_addr_t a, word_t d);
        tick();
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        tick();
        cfg_we    = 1'b0;
    endtask

    task automatic reg_read(reg_addr_t a, output word_t d);
        tick();
        cfg_addr = a;
        tick();
        d = cfg_rdata;
    endtask

    // Words go to consecutive addresses, so the model is updated up front.
    task automatic send_words(int n);
        word_t w;
        for (int i = 0; i < n; i++) begin
            w = $random(seed);
            model[model_wr_addr] = w;
            model_wr_addr = model_wr_addr + 1'b1;
            send_q.push_back(w);
        end
    endtask

    task automatic wait_in_drained();
        int n;
        n = 0;
        while ((send_q.size() != 0 || in_returned != in_sent) && n < LIMIT) begin
            tick();
            n++;
        end
        if (send_q.size() != 0 || in_returned != in_sent) begin
            errors++;
            $display("At %0t sent words never all got their in_credit back", $time);
        end
        tick(); // The last credited word lands at the following edge.
    endtask

    task automatic run_read(addr_t base, len_t len, logic hold, logic again, int stream_n);
        int    n;
        int    first;
        word_t st;
        n = 0;
        while (pend_credit != 0 && n < LIMIT) begin
            tick();
            n++;
        end
        if (pend_credit != 0) begin
            errors++;
            $display("At %0t output credits from the previous read were not returned", $time);
        end
        for (int i = 0; i < len; i++) begin
            exp_q.push_back(model[addr_t'(base + i)]);
        end
        reg_write(REG_RD_BASE, word_t'(base));
        reg_write(REG_RD_LEN, word_t'(len));
        out_seen = 0;
        withhold = hold;
        reg_write(REG_CTRL, 32'h1);
        if (again) begin
            reg_write(REG_CTRL, 32'h1); // Busy by now, so this must be dropped.
        end
        send_words(stream_n);
        if (hold) begin
            first = (len < CREDITS) ? len : CREDITS;
            n = 0;
            while (out_seen < first && n < LIMIT) begin
                tick();
                n++;
            end
            if (out_seen < first) begin
                errors++;
                $display("At %0t the first words did not arrive before credits ran out", $time);
            end
            repeat (10) tick();
            check_len("out_valid count", len_t'(first), len_t'(out_seen));
            withhold = 1'b0;
        end
        n = 0;
        while (exp_q.size() != 0 && n < LIMIT) begin
            tick();
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("At %0t the read stream stopped with %0d words missing", $time,
                     exp_q.size());
        end
        repeat (4) tick();
        check_len("out_valid count", len, len_t'(out_seen));
        reg_read(REG_STATUS, st);
        check_bit("busy", 1'b0, st[0]);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = REG_WR_BASE;
        cfg_wdata  = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_credit = 1'b0;
        withhold   = 1'b0;
        seed       = 32'hb2ab1d21;
        in_sent    = 0;
        in_returned = 0;
        out_seen   = 0;
        pend_credit = 0;
        errors     = 0;
        checks     = 0;
        model_wr_addr = '0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end

        // wr_base, count, rd_base, rd_len, hold, conc, again
        tests[0] = '{6'd0,  7'd16, 6'd0,  7'd16, 1'b0, 1'b0, 1'b0};
        tests[1] = '{6'd60, 7'd8,  6'd62, 7'd6,  1'b0, 1'b0, 1'b0}; // Wraps past the top.
        tests[2] = '{6'd20, 7'd12, 6'd20, 7'd12, 1'b1, 1'b0, 1'b0};
        tests[3] = '{6'd40, 7'd10, 6'd0,  7'd16, 1'b0, 1'b1, 1'b0};
        tests[4] = '{6'd10, 7'd5,  6'd8,  7'd8,  1'b0, 1'b0, 1'b1};
        tests[5] = '{6'd0,  7'd64, 6'd0,  7'd64, 1'b0, 1'b0, 1'b0};

        repeat (4) tick();
        rst = 1'b0;

        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_credit", 1'b0, in_credit);
        reg_read(REG_STATUS, rdata);
        check_bit("busy", 1'b0, rdata[0]);
        check_len("wr_count", '0, len_t'(rdata[14:8]));
        reg_write(REG_WR_BASE, 32'h15);
        reg_read(REG_WR_BASE, rdata);
        check_word("wr_base", 32'h15, rdata);
        reg_write(REG_RD_BASE, 32'h2a);
        reg_read(REG_RD_BASE, rdata);
        check_word("rd_base", 32'h2a, rdata);
        reg_write(REG_RD_LEN, 32'h40);
        reg_read(REG_RD_LEN, rdata);
        check_word("rd_len", 32'h40, rdata);

        for (int t = 0; t < N_TESTS; t++) begin
            e = tests[t];
            wait_in_drained();
            reg_write(REG_WR_BASE, word_t'(e.wr_base));
            model_wr_addr = e.wr_base;
            if (e.conc) begin
                run_read(e.rd_base, e.rd_len, e.hold, e.again, int'(e.wr_num));
                wait_in_drained();
                run_read(e.wr_base, e.wr_num, 1'b0, 1'b0, 0);
            end else begin
                send_words(int'(e.wr_num));
                wait_in_drained();
                run_read(e.rd_base, e.rd_len, e.hold, e.again, 0);
            end
            reg_read(REG_STATUS, rdata);
            check_len("wr_count", e.wr_num, len_t'(rdata[14:8]));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/buf_pkg.sv
rtl/cfg_pkg.sv
rtl/sram_wrap.sv
rtl/buf_cfg_regs.sv
rtl/buf_writer.sv
rtl/buf_reader.sv
rtl/tile_buf_top.sv
dv/tile_buf_tb.sv

// ==== Bender.yml ====
package:
  name: tile_buf

sources:
  - rtl/buf_pkg.sv
  - rtl/cfg_pkg.sv
  - rtl/sram_wrap.sv
  - rtl/buf_cfg_regs.sv
  - rtl/buf_writer.sv
  - rtl/buf_reader.sv
  - rtl/tile_buf_top.sv
  - target: test
    files:
      - dv/tile_buf_tb.sv
